//--- dv/draw_fpv_assertions.sv
module draw_fpv_assertions #(
    parameter int CREDIT_W = 3,
    parameter int MAX_CREDITS = 4
) (
    input logic clock,
    input logic reset,
    input logic [CREDIT_W-1:0] credits,
    input logic vga_write,
    input logic vga_credit,
    input logic done,
    input logic [2:0] gnt
);
    timeunit 1ns;
    timeprecision 100ps;

    // Pixels written and not yet paid back by the sink
    int outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(vga_write) - int'(vga_credit);
        end
    end

    // A count that wrapped below zero shows up above the limit
    credit_range: assert property (@(posedge clock) disable iff (reset)
        credits <= CREDIT_W'(MAX_CREDITS))
        else $error("credit count outside 0 to %0d", MAX_CREDITS);

    write_needs_credit: assert property (@(posedge clock) disable iff (reset)
        vga_write |-> outstanding < MAX_CREDITS)
        else $error("pixel write with no credit");

    grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(gnt))
        else $error("more than one grid grant at once");

    done_pulse: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind column_drawer draw_fpv_assertions #(
    .CREDIT_W(CREDIT_W),
    .MAX_CREDITS(VGA_CREDITS)
) drawer_checks (
    .clock(clock),
    .reset(reset),
    .credits(credits),
    .vga_write(vga_write),
    .vga_credit(vga_credit),
    .done(done),
    .gnt(3'b000)
);

bind grid_arbiter draw_fpv_assertions arbiter_checks (
    .clock(clock),
    .reset(reset),
    .credits(3'd0),
    .vga_write(1'b0),
    .vga_credit(1'b0),
    .done(1'b0),
    .gnt({fetch.gnt, ray.gnt, host.gnt})
);

//--- dv/draw_fpv_tb.sv
module draw_fpv_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fpv_pkg::*;

    localparam int COLUMNS = 160;
    localparam int ROWS = 120;
    localparam int VGA_CREDITS = 4;
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * COLUMNS * (ROWS + 2 * int'(MAX_STEPS) + 20) * 4;
    localparam logic [31:0] SEED = 32'h0d99_6c34;
    localparam int MAP_BORDER = 0;
    localparam int MAP_MIXED = 1;
    localparam int MAP_OPEN = 2;

    logic clock;
    logic reset;
    logic start;
    pos_x_t player_pos_x;
    pos_y_t player_pos_y;
    angle_t player_angle;
    logic grid_write;
    grid_x_t grid_write_x;
    grid_y_t grid_write_y;
    cell_t grid_write_cell;
    logic vga_credit;
    logic done;
    logic vga_write;
    screen_x_t vga_x;
    screen_y_t vga_y;
    colour_t vga_colour;

    cell_t map_model [0:2047];
    string current_test;
    logic frame_active;
    logic random_credit_delay;
    int main_errors = 0;
    int pixel_errors = 0;
    int credit_errors = 0;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    // Compare process state
    int write_count = 0;
    int done_count = 0;
    int exp_x = 0;
    int exp_y = 0;
    int frame_errors = 0;
    int nonblack_count = 0;
    int col_lit = 0;
    int lit_min = 0;
    int lit_max = 0;
    logic seen_full = 1'b0;
    logic seen_dim = 1'b0;
    colour_t expected_colour;

    tb_clock_gen clk0 (
        .clock(clock),
        .reset(reset)
    );

    draw_fpv #(
        .COLUMNS(COLUMNS),
        .ROWS(ROWS),
        .VGA_CREDITS(VGA_CREDITS)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .start(start),
        .player_pos_x(player_pos_x),
        .player_pos_y(player_pos_y),
        .player_angle(player_angle),
        .grid_write(grid_write),
        .grid_write_x(grid_write_x),
        .grid_write_y(grid_write_y),
        .grid_write_cell(grid_write_cell),
        .vga_credit(vga_credit),
        .done(done),
        .vga_write(vga_write),
        .vga_x(vga_x),
        .vga_y(vga_y),
        .vga_colour(vga_colour)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cell_t map_cell(input int kind, input int x, input int y);
        logic edge_cell;
        logic pillar;
        cell_t colour;
        edge_cell = (x == 0) || (x == 63) || (y == 0) || (y == 31);
        pillar = (x % 4 == 2) && (y % 4 == 2);
        colour = cell_t'(((x * 5 + y * 3) % 7) + 1);
        if (kind == MAP_BORDER) begin
            return edge_cell ? 3'b110 : 3'b000;
        end else if (kind == MAP_MIXED) begin
            return (edge_cell || pillar) ? colour : 3'b000;
        end
        return 3'b000;
    endfunction

    // March the column's ray through the map model, then apply the band and shade rules
    function automatic colour_t expected_pixel(input int px, input int py);
        angle_t a;
        step_t sx;
        step_t sy;
        int xi;
        int yi;
        int prev_cell_x;
        int steps;
        int half;
        logic vert;
        cell_t c;
        logic [10:0] addr;
        logic [5:0] on_level;
        a = player_angle + angle_t'(px) - angle_t'(COLUMNS / 2);
        sx = sine_step(a + 8'd64);
        sy = sine_step(a);
        xi = int'(player_pos_x);
        yi = int'(player_pos_y);
        steps = 0;
        vert = 1'b0;
        c = '0;
        while (c == '0 && steps < int'(MAX_STEPS)) begin
            prev_cell_x = xi >> FRAC_BITS;
            xi = (xi + int'(sx) + 16384) % 16384;
            yi = (yi + int'(sy) + 8192) % 8192;
            vert = (xi >> FRAC_BITS) != prev_cell_x;
            steps++;
            addr = {grid_y_t'(yi >> FRAC_BITS), grid_x_t'(xi >> FRAC_BITS)};
            c = map_model[addr];
        end
        if (steps == int'(MAX_STEPS)) begin
            return '0;
        end
        half = (ROWS / 2) >> (steps / 16);
        if (py < ROWS / 2 - half || py >= ROWS / 2 + half) begin
            return '0;
        end
        on_level = vert ? 6'h3f : 6'h30;
        return {c[2] ? on_level : 6'h00, c[1] ? on_level : 6'h00, c[0] ? on_level : 6'h00};
    endfunction

    function automatic int total_errors();
        return main_errors + pixel_errors + credit_errors;
    endfunction

    task automatic write_cell(input int x, input int y, input cell_t c);
        logic [10:0] addr;
        @(posedge clock);
        #1;
        grid_write = 1'b1;
        grid_write_x = grid_x_t'(x);
        grid_write_y = grid_y_t'(y);
        grid_write_cell = c;
        addr = 11'(y * 64 + x);
        map_model[addr] = c;
    endtask

    task automatic release_grid();
        @(posedge clock);
        #1;
        grid_write = 1'b0;
    endtask

    task automatic load_map(input int kind);
        for (int y = 0; y < 32; y++) begin
            for (int x = 0; x < 64; x++) begin
                write_cell(x, y, map_cell(kind, x, y));
            end
        end
        release_grid();
    endtask

    task automatic run_frame(input pos_x_t px, input pos_y_t py, input angle_t a,
                             input logic random_delays);
        @(posedge clock);
        #1;
        player_pos_x = px;
        player_pos_y = py;
        player_angle = a;
        random_credit_delay = random_delays;
        frame_active = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        while (done_count == 0) @(posedge clock);
        frame_active = 1'b0;
        // Time for stray writes or a second done to show
        repeat (20) @(posedge clock);
        if (done_count != 1) begin
            main_errors++;
            $display("ERR %s done pulses expected 1 actual %0d", current_test, done_count);
        end
        if (write_count != COLUMNS * ROWS) begin
            main_errors++;
            $display("ERR %s write count expected %0d actual %0d",
                     current_test, COLUMNS * ROWS, write_count);
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - errors_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: pass", current_test);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", current_test, n);
        end
    endtask

    always @(negedge clock) begin
        if (start) begin
            write_count = 0;
            done_count = 0;
            exp_x = 0;
            exp_y = 0;
            frame_errors = 0;
            nonblack_count = 0;
            col_lit = 0;
            lit_min = ROWS + 1;
            lit_max = 0;
            seen_full = 1'b0;
            seen_dim = 1'b0;
        end
        if ((vga_write || done) && !frame_active) begin
            pixel_errors++;
            $display("%s: DUT output active while no frame was running", current_test);
        end
        if (vga_write) begin
            expected_colour = expected_pixel(exp_x, exp_y);
            if (vga_x != screen_x_t'(exp_x) || vga_y != screen_y_t'(exp_y)) begin
                pixel_errors++;
                frame_errors++;
                if (frame_errors <= 8) begin
                    $display("ERR %s pixel %0d coordinates expected (%0d,%0d) actual (%0d,%0d)",
                             current_test, write_count, exp_x, exp_y, vga_x, vga_y);
                end
            end
            if (vga_colour != expected_colour) begin
                pixel_errors++;
                frame_errors++;
                if (frame_errors <= 8) begin
                    $display("ERR %s pixel (%0d,%0d) colour expected %05h actual %05h",
                             current_test, exp_x, exp_y, expected_colour, vga_colour);
                end
            end
            if (exp_y == 0) begin
                col_lit = 0;
            end
            if (vga_colour != '0) begin
                col_lit++;
                nonblack_count++;
            end
            if (vga_colour[17:12] == 6'h3f || vga_colour[11:6] == 6'h3f
                    || vga_colour[5:0] == 6'h3f) begin
                seen_full = 1'b1;
            end
            if (vga_colour[17:12] == 6'h30 || vga_colour[11:6] == 6'h30
                    || vga_colour[5:0] == 6'h30) begin
                seen_dim = 1'b1;
            end
            write_count++;
            if (exp_y == ROWS - 1) begin
                if (col_lit > 0 && col_lit < lit_min) begin
                    lit_min = col_lit;
                end
                if (col_lit > lit_max) begin
                    lit_max = col_lit;
                end
                exp_y = 0;
                exp_x++;
            end else begin
                exp_y++;
            end
        end
        if (done) begin
            done_count++;
            if (write_count != COLUMNS * ROWS) begin
                pixel_errors++;
                $display("ERR %s writes before done expected %0d actual %0d",
                         current_test, COLUMNS * ROWS, write_count);
            end
        end
    end

    // Sink model, one credit back per accepted pixel after 0 to 3 cycles
    initial begin
        int due [0:7];
        int pending;
        int cycle;
        int tb_credits;
        int delay;
        logic [31:0] rng;
        logic [2:0] slot;
        vga_credit = 1'b0;
        pending = 0;
        cycle = 0;
        tb_credits = VGA_CREDITS;
        rng = SEED;
        for (int i = 0; i < 8; i++) begin
            due[i] = 0;
        end
        forever begin
            @(negedge clock);
            if (vga_write) begin
                if (tb_credits == 0) begin
                    credit_errors++;
                    $display("%s: pixel written with no credit left", current_test);
                end
                delay = 0;
                if (random_credit_delay) begin
                    rng = xorshift32(rng);
                    delay = int'(rng[1:0]);
                end
                slot = 3'(cycle + 1 + delay);
                due[slot] += 1;
            end
            tb_credits = tb_credits - (vga_write ? 1 : 0) + (vga_credit ? 1 : 0);
            @(posedge clock);
            #1;
            cycle++;
            slot = 3'(cycle);
            pending += due[slot];
            due[slot] = 0;
            if (pending > 0) begin
                vga_credit = 1'b1;
                pending--;
            end else begin
                vga_credit = 1'b0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        start = 1'b0;
        player_pos_x = '0;
        player_pos_y = '0;
        player_angle = '0;
        grid_write = 1'b0;
        grid_write_x = '0;
        grid_write_y = '0;
        grid_write_cell = '0;
        frame_active = 1'b0;
        random_credit_delay = 1'b0;
        current_test = "reset";
        tests_run = 0;
        tests_failed = 0;
        while (reset !== 1'b0) @(posedge clock);

        begin_test("reset_idle");
        repeat (100) begin
            @(negedge clock);
            if (done !== 1'b0) begin
                main_errors++;
                $display("ERR %s done expected 0 actual %b", current_test, done);
            end
            if (vga_write !== 1'b0) begin
                main_errors++;
                $display("ERR %s vga_write expected 0 actual %b", current_test, vga_write);
            end
        end
        end_test();

        begin_test("border_frame");
        load_map(MAP_BORDER);
        run_frame({6'd4, 8'h80}, {5'd4, 8'h80}, 8'd160, 1'b0);
        end_test();

        begin_test("mixed_frame");
        load_map(MAP_MIXED);
        run_frame({6'd9, 8'h80}, {5'd9, 8'h80}, 8'd40, 1'b0);
        if (!seen_full || !seen_dim) begin
            main_errors++;
            $display("%s: frame did not show both vertical and horizontal sides", current_test);
        end
        if (lit_max <= lit_min) begin
            main_errors++;
            $display("%s: wall bands did not change height with depth", current_test);
        end
        end_test();

        begin_test("credit_delay");
        run_frame({6'd21, 8'h4c}, {5'd13, 8'hb3}, 8'd100, 1'b1);
        end_test();

        begin_test("open_frame");
        load_map(MAP_OPEN);
        run_frame({6'd32, 8'h80}, {5'd16, 8'h80}, 8'd0, 1'b0);
        if (nonblack_count != 0) begin
            main_errors++;
            $display("ERR %s lit pixels expected 0 actual %0d", current_test, nonblack_count);
        end
        end_test();

        begin_test("back_to_back");
        load_map(MAP_MIXED);
        run_frame({6'd30, 8'h20}, {5'd20, 8'he0}, 8'd230, 1'b1);
        for (int x = 6; x < 12; x++) begin
            write_cell(x, 6, cell_t'((x % 7) + 1));
            write_cell(x, 11, cell_t'(((x + 3) % 7) + 1));
        end
        release_grid();
        run_frame({6'd8, 8'h40}, {5'd8, 8'hc0}, 8'd200, 1'b0);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Held for the first ten rising edges
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- hdl/column_drawer.sv
module column_drawer #(
    parameter int ROWS = 120,
    parameter int VGA_CREDITS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  fpv_pkg::screen_x_t column,
    input  fpv_pkg::grid_x_t hit_x,
    input  fpv_pkg::grid_y_t hit_y,
    input  logic hit_vertical,
    input  fpv_pkg::depth_t depth,
    grid_port_if.requester grid,
    input  logic vga_credit,
    output logic done,
    output logic vga_write,
    output fpv_pkg::screen_x_t vga_x,
    output fpv_pkg::screen_y_t vga_y,
    output fpv_pkg::colour_t vga_colour
);
    import fpv_pkg::*;

    localparam int CREDIT_W = $clog2(VGA_CREDITS + 1);
    localparam int HALF_ROWS = ROWS / 2;

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_WAIT,
        D_DRAW
    } draw_state_t;

    draw_state_t state;
    screen_x_t column_q;
    grid_x_t hit_x_q;
    grid_y_t hit_y_q;
    logic vertical_q;
    depth_t depth_q;
    colour_t shade;
    colour_t colour_q;
    screen_y_t row;
    logic [CREDIT_W-1:0] credits;
    logic [7:0] half_h;
    logic [7:0] band_top;
    logic [7:0] band_bot;
    logic in_band;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= D_IDLE;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start) begin
                        state <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (grid.gnt) begin
                        state <= D_WAIT;
                    end
                end
                D_WAIT: begin
                    if (grid.rvalid) begin
                        state <= D_DRAW;
                    end
                end
                D_DRAW: begin
                    if (vga_write && row == screen_y_t'(ROWS - 1)) begin
                        state <= D_IDLE;
                        done <= 1'b1;
                    end
                end
                default: begin
                    state <= D_IDLE;
                end
            endcase
        end
    end

    // Full-intensity channels on vertical sides, dimmer on horizontal ones
    always_comb begin
        if (depth_q == MAX_STEPS) begin
            shade = '0;
        end else if (vertical_q) begin
            shade = {{6{grid.rdata[2]}}, {6{grid.rdata[1]}}, {6{grid.rdata[0]}}};
        end else begin
            shade = {{2{grid.rdata[2]}}, 4'b0000,
                     {2{grid.rdata[1]}}, 4'b0000,
                     {2{grid.rdata[0]}}, 4'b0000};
        end
    end

    always_ff @(posedge clock) begin
        if (state == D_IDLE && start) begin
            column_q <= column;
            hit_x_q <= hit_x;
            hit_y_q <= hit_y;
            vertical_q <= hit_vertical;
            depth_q <= depth;
        end
        if (grid.rvalid) begin
            colour_q <= shade;
            row <= '0;
        end else if (vga_write) begin
            row <= row + 7'd1;
        end
    end

    // Credits out on a write, back on a sink pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_W'(VGA_CREDITS);
        end else begin
            case ({vga_write, vga_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Half-height halves every 16 steps
    assign half_h = 8'(HALF_ROWS) >> depth_q[7:4];
    assign band_top = 8'(HALF_ROWS) - half_h;
    assign band_bot = 8'(HALF_ROWS) + half_h;
    assign in_band = ({1'b0, row} >= band_top) && ({1'b0, row} < band_bot);

    assign grid.req = state == D_FETCH;
    assign grid.write = 1'b0;
    assign grid.wdata = '0;
    assign grid.x = hit_x_q;
    assign grid.y = hit_y_q;

    assign vga_write = (state == D_DRAW) && (credits != '0);
    assign vga_x = column_q;
    assign vga_y = row;
    assign vga_colour = in_band ? colour_q : '0;

endmodule

//--- hdl/column_sequencer.sv
module column_sequencer #(
    parameter int COLUMNS = 160
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic done,
    output logic ray_start,
    input  logic ray_done,
    output logic draw_start,
    input  logic draw_done,
    input  fpv_pkg::angle_t player_angle,
    output fpv_pkg::angle_t ray_angle,
    output fpv_pkg::screen_x_t column
);
    import fpv_pkg::*;

    seq_state_t state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      state <= start ? INIT : IDLE;
                INIT:      state <= CAST;
                CAST:      state <= WAIT_CAST;
                WAIT_CAST: state <= ray_done ? DRAW : WAIT_CAST;
                DRAW:      state <= WAIT_DRAW;
                WAIT_DRAW: begin
                    if (draw_done) begin
                        state <= (column == screen_x_t'(COLUMNS - 1)) ? FINISH : NEXT;
                    end
                end
                NEXT:      state <= CAST;
                FINISH:    state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset || state == INIT) begin
            column <= '0;
        end else if (state == NEXT) begin
            column <= column + 8'd1;
        end
    end

    // Column offset from screen centre, wraps at a full turn
    assign ray_angle = player_angle + angle_t'(column) - angle_t'(COLUMNS / 2);

    assign ray_start = state == CAST;
    assign draw_start = state == DRAW;
    assign done = state == FINISH;

endmodule

//--- hdl/draw_fpv.sv
module draw_fpv #(
    parameter int COLUMNS = 160,
    parameter int ROWS = 120,
    parameter int VGA_CREDITS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  fpv_pkg::pos_x_t player_pos_x,
    input  fpv_pkg::pos_y_t player_pos_y,
    input  fpv_pkg::angle_t player_angle,
    input  logic grid_write,
    input  fpv_pkg::grid_x_t grid_write_x,
    input  fpv_pkg::grid_y_t grid_write_y,
    input  fpv_pkg::cell_t grid_write_cell,
    input  logic vga_credit,
    output logic done,
    output logic vga_write,
    output fpv_pkg::screen_x_t vga_x,
    output fpv_pkg::screen_y_t vga_y,
    output fpv_pkg::colour_t vga_colour
);
    import fpv_pkg::*;

    logic ray_start;
    logic ray_done;
    logic draw_start;
    logic draw_done;
    angle_t ray_angle;
    screen_x_t column;
    grid_x_t hit_x;
    grid_y_t hit_y;
    logic hit_vertical;
    depth_t depth;

    grid_port_if host ();
    grid_port_if ray ();
    grid_port_if fetch ();

    // Host loader only ever writes
    assign host.req = grid_write;
    assign host.write = 1'b1;
    assign host.x = grid_write_x;
    assign host.y = grid_write_y;
    assign host.wdata = grid_write_cell;

    column_sequencer #(.COLUMNS(COLUMNS)) seq0 (
        .clock(clock),
        .reset(reset),
        .start(start),
        .done(done),
        .ray_start(ray_start),
        .ray_done(ray_done),
        .draw_start(draw_start),
        .draw_done(draw_done),
        .player_angle(player_angle),
        .ray_angle(ray_angle),
        .column(column)
    );

    ray_marcher rm0 (
        .clock(clock),
        .reset(reset),
        .start(ray_start),
        .angle(ray_angle),
        .pos_x(player_pos_x),
        .pos_y(player_pos_y),
        .grid(ray),
        .done(ray_done),
        .hit_x(hit_x),
        .hit_y(hit_y),
        .hit_vertical(hit_vertical),
        .depth(depth)
    );

    column_drawer #(.ROWS(ROWS), .VGA_CREDITS(VGA_CREDITS)) cd0 (
        .clock(clock),
        .reset(reset),
        .start(draw_start),
        .column(column),
        .hit_x(hit_x),
        .hit_y(hit_y),
        .hit_vertical(hit_vertical),
        .depth(depth),
        .grid(fetch),
        .vga_credit(vga_credit),
        .done(draw_done),
        .vga_write(vga_write),
        .vga_x(vga_x),
        .vga_y(vga_y),
        .vga_colour(vga_colour)
    );

    grid_arbiter arb0 (
        .clock(clock),
        .reset(reset),
        .host(host),
        .ray(ray),
        .fetch(fetch)
    );

endmodule

//--- hdl/fpv_pkg.sv
package fpv_pkg;

    // Map cell, bits are red, green, blue, zero is empty
    typedef logic [2:0] cell_t;

    typedef logic [5:0] grid_x_t;
    typedef logic [4:0] grid_y_t;

    // Cell index in the upper bits, fraction in the low FRAC_BITS
    typedef logic [13:0] pos_x_t;
    typedef logic [12:0] pos_y_t;

    typedef logic [7:0] angle_t;
    typedef logic signed [8:0] step_t;
    typedef logic [7:0] depth_t;

    typedef logic [7:0] screen_x_t;
    typedef logic [6:0] screen_y_t;
    typedef logic [17:0] colour_t;

    localparam int FRAC_BITS = 8;
    localparam depth_t MAX_STEPS = 8'd255;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        CAST,
        WAIT_CAST,
        DRAW,
        WAIT_DRAW,
        NEXT,
        FINISH
    } seq_state_t;

    // Quarter wave sampled at mid-steps, peak 32 is 1/8 cell
    function automatic step_t sine_step(input angle_t a);
        logic [3:0] idx;
        logic [5:0] mag;
        idx = a[6] ? ~a[5:2] : a[5:2];
        case (idx)
            4'd0:  mag = 6'd2;
            4'd1:  mag = 6'd5;
            4'd2:  mag = 6'd8;
            4'd3:  mag = 6'd11;
            4'd4:  mag = 6'd14;
            4'd5:  mag = 6'd16;
            4'd6:  mag = 6'd19;
            4'd7:  mag = 6'd21;
            4'd8:  mag = 6'd24;
            4'd9:  mag = 6'd26;
            4'd10: mag = 6'd27;
            4'd11: mag = 6'd29;
            4'd12: mag = 6'd30;
            4'd13: mag = 6'd31;
            default: mag = 6'd32;
        endcase
        return a[7] ? -step_t'({3'b000, mag}) : step_t'({3'b000, mag});
    endfunction

endpackage

//--- hdl/grid_arbiter.sv
module grid_arbiter (
    input logic clock,
    input logic reset,
    grid_port_if.arbiter host,
    grid_port_if.arbiter ray,
    grid_port_if.arbiter fetch
);
    import fpv_pkg::*;

    logic ram_en;
    logic ram_write;
    grid_x_t ram_x;
    grid_y_t ram_y;
    cell_t ram_wdata;
    cell_t ram_rdata;
    logic [2:0] rd_sel;

    // Host first, then ray, then fetch
    always_comb begin
        host.gnt = host.req;
        ray.gnt = ray.req && !host.req;
        fetch.gnt = fetch.req && !host.req && !ray.req;
    end

    always_comb begin
        ram_write = host.write;
        ram_x = host.x;
        ram_y = host.y;
        ram_wdata = host.wdata;
        if (ray.gnt) begin
            ram_write = ray.write;
            ram_x = ray.x;
            ram_y = ray.y;
            ram_wdata = ray.wdata;
        end else if (fetch.gnt) begin
            ram_write = fetch.write;
            ram_x = fetch.x;
            ram_y = fetch.y;
            ram_wdata = fetch.wdata;
        end
    end

    assign ram_en = host.req || ray.req || fetch.req;

    grid_ram ram0 (
        .clock(clock),
        .en(ram_en),
        .write(ram_write),
        .x(ram_x),
        .y(ram_y),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    // Which reader gets rvalid next cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_sel <= '0;
        end else begin
            rd_sel <= {fetch.gnt && !fetch.write,
                       ray.gnt && !ray.write,
                       host.gnt && !host.write};
        end
    end

    assign host.rdata = ram_rdata;
    assign ray.rdata = ram_rdata;
    assign fetch.rdata = ram_rdata;
    assign host.rvalid = rd_sel[0];
    assign ray.rvalid = rd_sel[1];
    assign fetch.rvalid = rd_sel[2];

endmodule

//--- hdl/grid_port_if.sv
interface grid_port_if;
    import fpv_pkg::*;

    logic req;
    logic gnt;
    logic write;
    grid_x_t x;
    grid_y_t y;
    cell_t wdata;
    cell_t rdata;
    logic rvalid;

    modport requester (
        output req, write, x, y, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, write, x, y, wdata,
        output gnt, rdata, rvalid
    );

endinterface

//--- hdl/grid_ram.sv
module grid_ram (
    input  logic clock,
    input  logic en,
    input  logic write,
    input  fpv_pkg::grid_x_t x,
    input  fpv_pkg::grid_y_t y,
    input  fpv_pkg::cell_t wdata,
    output fpv_pkg::cell_t rdata
);
    import fpv_pkg::*;

    // Row-major, y in the upper address bits
    cell_t mem [0:2047];
    logic [10:0] addr;

    assign addr = {y, x};

    always_ff @(posedge clock) begin
        if (en) begin
            if (write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- hdl/ray_marcher.sv
module ray_marcher (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  fpv_pkg::angle_t angle,
    input  fpv_pkg::pos_x_t pos_x,
    input  fpv_pkg::pos_y_t pos_y,
    grid_port_if.requester grid,
    output logic done,
    output fpv_pkg::grid_x_t hit_x,
    output fpv_pkg::grid_y_t hit_y,
    output logic hit_vertical,
    output fpv_pkg::depth_t depth
);
    import fpv_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_STEP,
        R_REQ,
        R_WAIT
    } march_state_t;

    march_state_t state;
    pos_x_t pos_x_q;
    pos_y_t pos_y_q;
    step_t step_x;
    step_t step_y;
    pos_x_t next_x;
    pos_y_t next_y;
    depth_t depth_q;
    logic vertical_q;

    // Sign-extend the step, indices wrap with the position width
    assign next_x = pos_x_q + {{5{step_x[8]}}, step_x};
    assign next_y = pos_y_q + {{4{step_y[8]}}, step_y};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= R_IDLE;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (start) begin
                        state <= R_STEP;
                    end
                end
                R_STEP: begin
                    state <= R_REQ;
                end
                R_REQ: begin
                    if (grid.gnt) begin
                        state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (grid.rvalid) begin
                        if (grid.rdata != '0 || depth_q == MAX_STEPS) begin
                            state <= R_IDLE;
                            done <= 1'b1;
                        end else begin
                            state <= R_STEP;
                        end
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == R_IDLE && start) begin
            pos_x_q <= pos_x;
            pos_y_q <= pos_y;
            // Cosine is sine a quarter turn on
            step_x <= sine_step(angle + 8'd64);
            step_y <= sine_step(angle);
            depth_q <= '0;
            vertical_q <= 1'b0;
        end else if (state == R_STEP) begin
            pos_x_q <= next_x;
            pos_y_q <= next_y;
            depth_q <= depth_q + 8'd1;
            vertical_q <= next_x[13:FRAC_BITS] != pos_x_q[13:FRAC_BITS];
        end
    end

    assign grid.req = state == R_REQ;
    assign grid.write = 1'b0;
    assign grid.wdata = '0;
    assign grid.x = pos_x_q[13:FRAC_BITS];
    assign grid.y = pos_y_q[12:FRAC_BITS];

    // Results hold until the next start
    assign hit_x = pos_x_q[13:FRAC_BITS];
    assign hit_y = pos_y_q[12:FRAC_BITS];
    assign hit_vertical = vertical_q;
    assign depth = depth_q;

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module draw_fpv_tb -Mdir obj_dir -o draw_fpv_sim -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/draw_fpv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

//--- verilog.f
hdl/fpv_pkg.sv
hdl/grid_port_if.sv
hdl/grid_ram.sv
hdl/grid_arbiter.sv
hdl/ray_marcher.sv
hdl/column_drawer.sv
hdl/column_sequencer.sv
hdl/draw_fpv.sv
dv/tb_clock_gen.sv
dv/draw_fpv_assertions.sv
dv/draw_fpv_tb.sv
